//--- files.f
hdl/rab_pkg.sv
hdl/rab_req_select.sv
hdl/rab_slice_table.sv
hdl/rab_xlate_fsm.sv
hdl/rab_core.sv
dv/rab_core_sva.sv
dv/rab_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rab_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rab_core_tb \
  -f files.f -o rab_core_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rab_core_tb > sim.log 2>&1 || true

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- dv/rab_core_tb.sv
// ########################################
// rab core testbench
// random and directed requests on both
// channels against a reference model
// ########################################

`timescale 1ns/1ps

module rab_core_tb;

  localparam int          CLK_PERIOD = 40;
  localparam logic [31:0] SEED       = 32'd88697;
  localparam int          N_TESTS    = 6;
  localparam int          N_SLICES   = 4;
  localparam int          IDX_W      = $clog2(N_SLICES);

  typedef struct packed {
    logic                        accept;
    logic                        miss;
    logic                        prot;
    logic                        multi;
    logic                        msel;
    logic [rab_pkg::PADDR_W-1:0] addr;
  } expect_t;

  logic                        Clk_CI;
  logic                        Rst_RBI;
  rab_pkg::rab_req_t           port1_req;
  rab_pkg::rab_req_t           port2_req;
  logic                        port1_valid;
  logic                        port2_valid;
  logic                        port1_sent;
  logic                        port2_sent;
  logic                        port1_accept;
  logic                        port1_drop;
  logic                        port2_accept;
  logic                        port2_drop;
  logic [rab_pkg::PADDR_W-1:0] out_addr;
  logic                        master_select;
  logic                        cfg_we;
  logic [IDX_W-1:0]            cfg_idx;
  rab_pkg::slice_cfg_t         cfg_slice;
  logic                        int_miss;
  logic                        int_prot;
  logic                        int_multi;

  logic [31:0]         lfsr_q;
  int                  err_cnt;
  int                  test_err0;
  int                  pass_cnt;
  int                  fail_cnt;
  logic                prio_p1;              // model of the DUT priority
  rab_pkg::slice_cfg_t slices_m [N_SLICES];  // model copy of the table

  rab_core #(
    .N_SLICES (N_SLICES)
  ) i_rab_core (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .port1_req     (port1_req),
    .port1_valid   (port1_valid),
    .port1_sent    (port1_sent),
    .port1_accept  (port1_accept),
    .port1_drop    (port1_drop),
    .port2_req     (port2_req),
    .port2_valid   (port2_valid),
    .port2_sent    (port2_sent),
    .port2_accept  (port2_accept),
    .port2_drop    (port2_drop),
    .out_addr      (out_addr),
    .master_select (master_select),
    .cfg_we        (cfg_we),
    .cfg_idx       (cfg_idx),
    .cfg_slice     (cfg_slice),
    .int_miss      (int_miss),
    .int_prot      (int_prot),
    .int_multi     (int_multi)
  );

  bind rab_core rab_core_sva i_rab_core_sva (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .state         (i_rab_xlate_fsm.state_q),
    .port1_accept  (port1_accept),
    .port1_drop    (port1_drop),
    .port2_accept  (port2_accept),
    .port2_drop    (port2_drop),
    .out_addr      (out_addr),
    .master_select (master_select),
    .int_miss      (int_miss),
    .int_prot      (int_prot),
    .int_multi     (int_multi)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) Clk_CI = ~Clk_CI;
    end
  end

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic rab_pkg::rab_req_t make_req(input logic [31:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic rw, input logic [5:0] ctrl);
    rab_pkg::rab_req_t r;
    r.addr = addr;
    r.len  = len;
    r.size = size;
    r.rw   = rw;
    r.ctrl = ctrl;
    return r;
  endfunction

  function automatic rab_pkg::slice_cfg_t make_slice(input logic [31:0] first,
      input logic [31:0] last, input logic [39:0] offset, input logic rd, input logic wr,
      input logic msel);
    rab_pkg::slice_cfg_t s;
    s.en         = 1'b1;
    s.rd_en      = rd;
    s.wr_en      = wr;
    s.mst_sel    = msel;
    s.addr_start = first;
    s.addr_end   = last;
    s.offset     = offset;
    return s;
  endfunction

  // outcome rule applied to the model table
  function automatic expect_t predict(input rab_pkg::rab_req_t r);
    expect_t     e;
    logic [31:0] lo;
    logic [31:0] hi;
    int          nhit;
    int          first;
    e     = '0;
    lo    = r.addr;
    hi    = (r.addr & ~((32'd1 << r.size) - 32'd1)) + ((32'(r.len) + 32'd1) << r.size) - 32'd1;
    nhit  = 0;
    first = 0;
    for (int i = N_SLICES - 1; i >= 0; i--)
    begin
      if (slices_m[i].en && lo >= slices_m[i].addr_start && hi <= slices_m[i].addr_end)
      begin
        nhit++;
        first = i;  // ends on the lowest index
      end
    end
    if (r.ctrl == {rab_pkg::CTRL_W{1'b1}})
    begin
      e.accept = 1'b1;
      e.addr   = 40'(r.addr);
    end
    else if (nhit == 0)
      e.miss = 1'b1;
    else if (nhit > 1)
      e.multi = 1'b1;
    else if (r.rw ? !slices_m[first].wr_en : !slices_m[first].rd_en)
      e.prot = 1'b1;
    else
    begin
      e.accept = 1'b1;
      e.msel   = slices_m[first].mst_sel;
      e.addr   = 40'(lo) - 40'(slices_m[first].addr_start) + slices_m[first].offset;
    end
    return e;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (exp === got)
    else
    begin
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic write_slice(input int idx, input rab_pkg::slice_cfg_t s);
    @(posedge Clk_CI);
    cfg_we    <= 1'b1;
    cfg_idx   <= IDX_W'(idx);
    cfg_slice <= s;
    @(posedge Clk_CI);
    cfg_we <= 1'b0;
    slices_m[idx] = s;
  endtask

  // present one or two requests, check every outcome until both are served
  task automatic issue(input logic v1, input logic v2,
      input rab_pkg::rab_req_t r1, input rab_pkg::rab_req_t r2);
    expect_t e1;
    expect_t e2;
    expect_t e;
    logic    pend1;
    logic    pend2;
    logic    exp_p1;
    logic    got_p1;
    string   pfx;
    int      d;
    e1    = predict(r1);
    e2    = predict(r2);
    pend1 = v1;
    pend2 = v2;
    @(posedge Clk_CI);
    port1_req   <= r1;
    port2_req   <= r2;
    port1_valid <= v1;
    port2_valid <= v2;
    while (pend1 || pend2)
    begin
      exp_p1 = pend1 && (prio_p1 || !pend2);
      @(negedge Clk_CI);
      while (!(port1_accept || port1_drop || port2_accept || port2_drop))
        @(negedge Clk_CI);
      got_p1 = port1_accept | port1_drop;
      pfx    = got_p1 ? "port1" : "port2";
      e      = got_p1 ? e1 : e2;
      check_val("served_port1", exp_p1, got_p1);
      check_val({pfx, "_accept"}, e.accept, got_p1 ? port1_accept : port2_accept);
      check_val({pfx, "_drop"}, !e.accept, got_p1 ? port1_drop : port2_drop);
      check_val("int_miss", e.miss, int_miss);
      check_val("int_prot", e.prot, int_prot);
      check_val("int_multi", e.multi, int_multi);
      if (e.accept)
      begin
        check_val("out_addr", e.addr, out_addr);
        check_val("master_select", e.msel, master_select);
      end
      prio_p1 = !got_p1;
      @(posedge Clk_CI);
      if (got_p1)
      begin
        port1_valid <= 1'b0;
        pend1 = 1'b0;
      end
      else
      begin
        port2_valid <= 1'b0;
        pend2 = 1'b0;
      end
      if (e.accept)
      begin
        d = int'(rand_bits(2));  // requester uses the address 0..3 cycles later
        repeat (d) @(posedge Clk_CI);
        port1_sent <= got_p1;
        port2_sent <= !got_p1;
        @(posedge Clk_CI);
        port1_sent <= 1'b0;
        port2_sent <= 1'b0;
      end
    end
  endtask

  task automatic send_one(input rab_pkg::rab_req_t r);
    if (rand_bits(1) == 32'd1)
      issue(1'b1, 1'b0, r, '0);
    else
      issue(1'b0, 1'b1, '0, r);
  endtask

  // bound checker failures count against the running test too
  task automatic close_test(input string name);
    int errs;
    errs = err_cnt + i_rab_core.i_rab_core_sva.fail_cnt;
    if (errs == test_err0)
    begin
      pass_cnt++;
      $display("test %-12s ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %-12s %0d error(s)", name, errs - test_err0);
    end
    test_err0 = errs;
  endtask

  initial
  begin
    rab_pkg::rab_req_t r;
    Rst_RBI     = 1'b0;
    port1_req   = '0;
    port2_req   = '0;
    port1_valid = 1'b0;
    port2_valid = 1'b0;
    port1_sent  = 1'b0;
    port2_sent  = 1'b0;
    cfg_we      = 1'b0;
    cfg_idx     = '0;
    cfg_slice   = '0;
    lfsr_q      = SEED;
    err_cnt     = 0;
    test_err0   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    prio_p1     = 1'b1;
    for (int i = 0; i < N_SLICES; i++)
      slices_m[i] = '0;
    repeat (10) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    write_slice(0, make_slice(32'h1000_0000, 32'h1000_ffff, 40'h80_0000_0000, 1, 1, 1));
    write_slice(1, make_slice(32'h2000_0000, 32'h2000_0fff, 40'h00_4000_0000, 1, 0, 0));
    write_slice(2, make_slice(32'h3000_0000, 32'h3000_0fff, 40'h01_0000_0000, 0, 1, 0));

    // port1 first after reset, then the priority alternates
    r = make_req(32'h1000_0100, 8'd3, 3'd2, 1'b0, 6'd0);
    issue(1'b1, 1'b1, r, make_req(32'h1000_0200, 8'd1, 3'd3, 1'b1, 6'd0));
    issue(1'b1, 1'b0, r, '0);
    issue(1'b1, 1'b1, r, make_req(32'h5000_0000, 8'd0, 3'd0, 1'b0, 6'd0));
    close_test("arbitration");

    for (int i = 0; i < 20; i++)
    begin
      r = make_req(32'h1000_0000 + rand_bits(14), 8'(rand_bits(4)), 3'(rand_bits(2)),
                   rand_bits(1) == 32'd1, 6'(rand_bits(5)));
      send_one(r);
    end
    close_test("translation");

    send_one(make_req(32'h5000_0000, 8'd0, 3'd2, 1'b0, 6'd0));
    send_one(make_req(32'h1000_fff0, 8'd7, 3'd2, 1'b1, 6'd0));  // burst runs past the end
    send_one(make_req(32'h1000_fffd, 8'd0, 3'd2, 1'b0, 6'd0));  // fits only once aligned
    close_test("miss");

    send_one(make_req(32'h2000_0040, 8'd0, 3'd2, 1'b1, 6'd0));
    send_one(make_req(32'h3000_0040, 8'd0, 3'd2, 1'b0, 6'd0));
    send_one(make_req(32'h2000_0080, 8'd3, 3'd2, 1'b0, 6'd0));  // allowed direction
    send_one(make_req(32'h3000_0080, 8'd3, 3'd2, 1'b1, 6'd0));
    close_test("protection");

    write_slice(3, make_slice(32'h1000_8000, 32'h1000_8fff, 40'h02_0000_0000, 1, 1, 0));
    send_one(make_req(32'h1000_8100, 8'd0, 3'd2, 1'b0, 6'd0));
    write_slice(3, '0);
    close_test("multi-hit");

    send_one(make_req(32'h7000_1234, 8'd2, 3'd1, 1'b1, 6'h3f));
    send_one(make_req(32'h1000_0400, 8'd0, 3'd2, 1'b0, 6'h3f));  // slice has mst_sel set
    close_test("bypass");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    #(CLK_PERIOD * 200 * N_TESTS);
    $display("watchdog expired, the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- dv/rab_core_sva.sv
// ########################################
// rab core timing checks
// handshake pulses, interrupts and the
// held translation, bound into rab_core
// ########################################

`timescale 1ns/1ps

module rab_core_sva
(
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  rab_pkg::xlate_state_e        state,
  input  logic                         port1_accept,
  input  logic                         port1_drop,
  input  logic                         port2_accept,
  input  logic                         port2_drop,
  input  logic [rab_pkg::PADDR_W-1:0]  out_addr,
  input  logic                         master_select,
  input  logic                         int_miss,
  input  logic                         int_prot,
  input  logic                         int_multi
);

  logic served;
  int   fail_cnt = 0;  // failed properties so far

  assign served = port1_accept | port1_drop | port2_accept | port2_drop;

  // outcome one edge after the lookup cycle
  lookup_to_outcome: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (state == rab_pkg::LOOKUP) |=> served)
    else
    begin
      $error("no accept or drop one cycle after lookup");
      fail_cnt++;
    end

  outcome_from_lookup: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    served |-> ($past(state) == rab_pkg::LOOKUP))
    else
    begin
      $error("accept or drop without a preceding lookup");
      fail_cnt++;
    end

  port1_excl: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(port1_accept && port1_drop))
    else
    begin
      $error("port1 accept and drop high together");
      fail_cnt++;
    end

  port2_excl: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(port2_accept && port2_drop))
    else
    begin
      $error("port2 accept and drop high together");
      fail_cnt++;
    end

  // a drop names exactly one cause
  drop_one_int: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (port1_drop || port2_drop) |-> $onehot({int_miss, int_prot, int_multi}))
    else
    begin
      $error("drop without exactly one interrupt");
      fail_cnt++;
    end

  hold_while_waiting: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (state == rab_pkg::WAIT_SENT) |=> ($stable(out_addr) && $stable(master_select)))
    else
    begin
      $error("translation changed before sent");
      fail_cnt++;
    end

endmodule

//--- hdl/rab_core.sv
// ########################################
// rab core
// one translation lane shared by two
// requesting channels
// ########################################

`timescale 1ns/1ps

module rab_core
#(
  parameter  int unsigned N_SLICES = 4,
  localparam int unsigned IDX_W    = (N_SLICES > 1) ? $clog2(N_SLICES) : 1
)
(
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  rab_pkg::rab_req_t            port1_req,
  input  logic                         port1_valid,
  input  logic                         port1_sent,
  output logic                         port1_accept,
  output logic                         port1_drop,
  input  rab_pkg::rab_req_t            port2_req,
  input  logic                         port2_valid,
  input  logic                         port2_sent,
  output logic                         port2_accept,
  output logic                         port2_drop,
  output logic [rab_pkg::PADDR_W-1:0]  out_addr,
  output logic                         master_select,
  input  logic                         cfg_we,
  input  logic [IDX_W-1:0]             cfg_idx,
  input  rab_pkg::slice_cfg_t          cfg_slice,
  output logic                         int_miss,
  output logic                         int_prot,
  output logic                         int_multi
);

  rab_pkg::lookup_t                sel_range;
  rab_pkg::lookup_t                lookup_range;  // registered, feeds the table
  rab_pkg::lookup_res_t            result;
  logic                            sel_port1;
  logic                            bypass;
  logic [rab_pkg::VADDR_W-1:0]     bypass_addr;
  logic                            served_port1;
  logic                            served_port2;

  rab_req_select i_rab_req_select (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .port1_req    (port1_req),
    .port2_req    (port2_req),
    .port1_valid  (port1_valid),
    .port2_valid  (port2_valid),
    .served_port1 (served_port1),
    .served_port2 (served_port2),
    .sel_range    (sel_range),
    .sel_port1    (sel_port1),
    .bypass       (bypass),
    .bypass_addr  (bypass_addr)
  );

  rab_slice_table #(
    .N_SLICES (N_SLICES)
  ) i_rab_slice_table (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .cfg_we    (cfg_we),
    .cfg_idx   (cfg_idx),
    .cfg_slice (cfg_slice),
    .range     (lookup_range),
    .result    (result)
  );

  rab_xlate_fsm i_rab_xlate_fsm (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .sel_range     (sel_range),
    .sel_port1     (sel_port1),
    .bypass        (bypass),
    .bypass_addr   (bypass_addr),
    .port1_valid   (port1_valid),
    .port2_valid   (port2_valid),
    .port1_sent    (port1_sent),
    .port2_sent    (port2_sent),
    .result        (result),
    .lookup_range  (lookup_range),
    .served_port1  (served_port1),
    .served_port2  (served_port2),
    .port1_accept  (port1_accept),
    .port1_drop    (port1_drop),
    .port2_accept  (port2_accept),
    .port2_drop    (port2_drop),
    .out_addr      (out_addr),
    .master_select (master_select),
    .int_miss      (int_miss),
    .int_prot      (int_prot),
    .int_multi     (int_multi)
  );

endmodule

//--- hdl/rab_xlate_fsm.sv
// ########################################
// rab translation controller
// latches a request, applies the lookup
// outcome and waits for sent on accept
// ########################################

`timescale 1ns/1ps

module rab_xlate_fsm
(
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  rab_pkg::lookup_t             sel_range,
  input  logic                         sel_port1,
  input  logic                         bypass,
  input  logic [rab_pkg::VADDR_W-1:0]  bypass_addr,
  input  logic                         port1_valid,
  input  logic                         port2_valid,
  input  logic                         port1_sent,
  input  logic                         port2_sent,
  input  rab_pkg::lookup_res_t         result,
  output rab_pkg::lookup_t             lookup_range,
  output logic                         served_port1,
  output logic                         served_port2,
  output logic                         port1_accept,
  output logic                         port1_drop,
  output logic                         port2_accept,
  output logic                         port2_drop,
  output logic [rab_pkg::PADDR_W-1:0]  out_addr,
  output logic                         master_select,
  output logic                         int_miss,
  output logic                         int_prot,
  output logic                         int_multi
);

  localparam int unsigned VW = rab_pkg::VADDR_W;

  rab_pkg::xlate_state_e state_q;
  logic                  port1_q;      // channel under lookup
  logic                  bypass_q;
  logic [VW-1:0]         bypass_addr_q;
  logic                  sample;
  logic                  do_accept;
  logic                  miss_d;
  logic                  multi_d;
  logic                  prot_d;
  logic                  sent;

  assign served_port1 = port1_accept | port1_drop;
  assign served_port2 = port2_accept | port2_drop;

  // the requester still holds valid while its pulse is out
  assign sample = (state_q == rab_pkg::IDLE) & (port1_valid | port2_valid)
                & ~(served_port1 | served_port2);

  // outcome rule, first match wins
  assign miss_d    = ~bypass_q & ~result.hit;
  assign multi_d   = ~bypass_q & result.hit & result.multi;
  assign prot_d    = ~bypass_q & result.hit & ~result.multi & result.prot;
  assign do_accept = ~(miss_d | multi_d | prot_d);
  assign sent      = port1_q ? port1_sent : port2_sent;

  // request payload
  always_ff @(posedge Clk_CI)
  begin
    if (sample)
    begin
      lookup_range  <= sel_range;
      bypass_addr_q <= bypass_addr;
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q       <= rab_pkg::IDLE;
      port1_q       <= 1'b0;
      bypass_q      <= 1'b0;
      port1_accept  <= 1'b0;
      port1_drop    <= 1'b0;
      port2_accept  <= 1'b0;
      port2_drop    <= 1'b0;
      out_addr      <= '0;
      master_select <= 1'b0;
      int_miss      <= 1'b0;
      int_prot      <= 1'b0;
      int_multi     <= 1'b0;
    end
    else
    begin
      port1_accept <= 1'b0;  // all pulses last one cycle
      port1_drop   <= 1'b0;
      port2_accept <= 1'b0;
      port2_drop   <= 1'b0;
      int_miss     <= 1'b0;
      int_prot     <= 1'b0;
      int_multi    <= 1'b0;
      case (state_q)
        rab_pkg::IDLE:
        begin
          if (sample)
          begin
            port1_q  <= sel_port1;
            bypass_q <= bypass;
            state_q  <= rab_pkg::LOOKUP;
          end
        end
        rab_pkg::LOOKUP:
        begin
          port1_accept <= port1_q & do_accept;
          port1_drop   <= port1_q & ~do_accept;
          port2_accept <= ~port1_q & do_accept;
          port2_drop   <= ~port1_q & ~do_accept;
          int_miss     <= miss_d;
          int_multi    <= multi_d;
          int_prot     <= prot_d;
          if (do_accept)
          begin
            out_addr      <= bypass_q ? rab_pkg::PADDR_W'(bypass_addr_q) : result.out_addr;
            master_select <= ~bypass_q & result.mst_sel;
            state_q       <= rab_pkg::WAIT_SENT;
          end
          else
          begin
            state_q <= rab_pkg::IDLE;
          end
        end
        rab_pkg::WAIT_SENT:
        begin
          if (sent)
          begin
            state_q <= rab_pkg::IDLE;  // out_addr held until here
          end
        end
        default:
        begin
          state_q <= rab_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

//--- hdl/rab_slice_table.sv
// ########################################
// rab slice table
// slice storage written by strobe and a
// parallel range / protection match
// ########################################

`timescale 1ns/1ps

module rab_slice_table
#(
  parameter  int unsigned N_SLICES = 4,
  localparam int unsigned IDX_W    = (N_SLICES > 1) ? $clog2(N_SLICES) : 1
)
(
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  input  logic                  cfg_we,
  input  logic [IDX_W-1:0]      cfg_idx,
  input  rab_pkg::slice_cfg_t   cfg_slice,
  input  rab_pkg::lookup_t      range,
  output rab_pkg::lookup_res_t  result
);

  localparam int unsigned PW = rab_pkg::PADDR_W;

  rab_pkg::slice_cfg_t slices_q [N_SLICES];
  logic [N_SLICES-1:0] hit_vec;
  logic [N_SLICES-1:0] prot_vec;

  // all slices come out of reset disabled
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int i = 0; i < N_SLICES; i++)
      begin
        slices_q[i] <= '0;
      end
    end
    else if (cfg_we)
    begin
      slices_q[cfg_idx] <= cfg_slice;
    end
  end

  // whole burst must sit inside the slice
  always_comb
  begin
    for (int i = 0; i < N_SLICES; i++)
    begin
      hit_vec[i]  = slices_q[i].en
                  & (range.addr_min >= slices_q[i].addr_start)
                  & (range.addr_max <= slices_q[i].addr_end);
      prot_vec[i] = range.rw ? ~slices_q[i].wr_en : ~slices_q[i].rd_en;
    end
  end

  // result taken from the lowest-index hit
  always_comb
  begin
    logic found;
    found  = 1'b0;
    result = '0;
    for (int i = 0; i < N_SLICES; i++)
    begin
      if (hit_vec[i] && !found)
      begin
        found           = 1'b1;
        result.prot     = prot_vec[i];
        result.mst_sel  = slices_q[i].mst_sel;
        result.out_addr = PW'(range.addr_min) - PW'(slices_q[i].addr_start)
                        + slices_q[i].offset;
      end
    end
    result.hit   = found;
    result.multi = |(hit_vec & (hit_vec - 1'b1));  // more than one bit set
  end

endmodule

//--- hdl/rab_req_select.sv
// ########################################
// rab request select
// two-channel priority, request mux,
// bypass detect and burst byte range
// ########################################

`timescale 1ns/1ps

module rab_req_select
(
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  rab_pkg::rab_req_t            port1_req,
  input  rab_pkg::rab_req_t            port2_req,
  input  logic                         port1_valid,
  input  logic                         port2_valid,
  input  logic                         served_port1,
  input  logic                         served_port2,
  output rab_pkg::lookup_t             sel_range,
  output logic                         sel_port1,
  output logic                         bypass,
  output logic [rab_pkg::VADDR_W-1:0]  bypass_addr
);

  localparam int unsigned VW = rab_pkg::VADDR_W;

  logic              prio_port1_q;  // 1: port1 wins a tie
  rab_pkg::rab_req_t sel_req;
  logic [VW-1:0]     align_mask;
  logic [VW-1:0]     align_addr;
  logic [15:0]       beats;
  logic [15:0]       burst_bytes;

  // priority flips to the other channel once a channel is served
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      prio_port1_q <= 1'b1;
    end
    else if (served_port1)
    begin
      prio_port1_q <= 1'b0;
    end
    else if (served_port2)
    begin
      prio_port1_q <= 1'b1;
    end
  end

  // lone valid wins, otherwise priority decides
  assign sel_port1 = port1_valid & (prio_port1_q | ~port2_valid);
  assign sel_req   = sel_port1 ? port1_req : port2_req;

  always_comb
  begin
    // clear the byte offset within one beat
    align_mask  = {VW{1'b1}} << sel_req.size;
    align_addr  = sel_req.addr & align_mask;
    beats       = 16'(sel_req.len) + 16'd1;
    burst_bytes = beats << sel_req.size;  // at most 256 << 7

    sel_range.addr_min = sel_req.addr;
    sel_range.addr_max = align_addr + VW'(burst_bytes) - VW'(1);
    sel_range.rw       = sel_req.rw;
  end

  assign bypass      = (sel_req.ctrl == {rab_pkg::CTRL_W{1'b1}});
  assign bypass_addr = sel_req.addr;  // passed on untranslated

endmodule

//--- hdl/rab_pkg.sv
// ########################################
// rab package
// widths, request and slice structs, and
// the lookup controller states
// ########################################

package rab_pkg;

  localparam int unsigned VADDR_W = 32;  // virtual (slave side) address
  localparam int unsigned PADDR_W = 40;  // physical (master side) address
  localparam int unsigned CTRL_W  = 6;   // user control field, all ones = bypass

  // one request as seen on a channel
  typedef struct packed {
    logic [VADDR_W-1:0] addr;
    logic [7:0]         len;   // beats minus one
    logic [2:0]         size;  // log2 of bytes per beat
    logic               rw;    // 1 = write
    logic [CTRL_W-1:0]  ctrl;
  } rab_req_t;

  // byte range handed to the slice table
  typedef struct packed {
    logic [VADDR_W-1:0] addr_min;  // unaligned start
    logic [VADDR_W-1:0] addr_max;  // last byte of the aligned burst
    logic               rw;
  } lookup_t;

  // one slice entry
  typedef struct packed {
    logic               en;
    logic               rd_en;
    logic               wr_en;
    logic               mst_sel;
    logic [VADDR_W-1:0] addr_start;
    logic [VADDR_W-1:0] addr_end;
    logic [PADDR_W-1:0] offset;
  } slice_cfg_t;

  // table answer for the current range
  typedef struct packed {
    logic               hit;
    logic               multi;
    logic               prot;
    logic               mst_sel;
    logic [PADDR_W-1:0] out_addr;
  } lookup_res_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_SENT
  } xlate_state_e;

endpackage
